// ==== hw/leaf_pkg.sv ====
package leaf_pkg;

    localparam int PACKET_BITS  = 49;
    localparam int PAYLOAD_BITS = 32;
    localparam int LEAF_BITS    = 5;
    localparam int PORT_BITS    = 4;
    localparam int ADDR_BITS    = 7;

    // One network packet, valid in the top bit
    typedef struct packed {
        logic                    valid;
        logic [LEAF_BITS-1:0]    leaf;
        logic [PORT_BITS-1:0]    port;
        logic [ADDR_BITS-1:0]    addr;
        logic [PAYLOAD_BITS-1:0] payload;
    } leaf_packet_t;

    // Kind sits in addr[6:5] of a control packet
    typedef enum logic [1:0] {
        CFG_NONE       = 2'd0,
        CFG_SET_DEST   = 2'd1,
        CFG_ADD_CREDIT = 2'd2
    } cfg_kind_e;

    // out_port is the output index 0 to 2, taken from addr[1:0]
    typedef struct packed {
        cfg_kind_e               kind;
        logic [1:0]              out_port;
        logic [PAYLOAD_BITS-1:0] value;    // Destination {leaf, port} or credit count
    } cfg_cmd_t;

    typedef struct packed {
        logic                    vld;
        logic [PAYLOAD_BITS-1:0] data;
    } kernel_result_t;

    typedef enum logic {
        TX_IDLE = 1'b0,
        TX_SEND = 1'b1
    } tx_state_e;

endpackage

// ==== hw/port_fifo.sv ====
`timescale 1ns/1ps

module port_fifo #(
    parameter int DEPTH = 8
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        wr,
    input  logic [31:0] wr_data,
    output logic [31:0] rd_data,
    output logic        vld,
    input  logic        ack
);

    localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_BITS = $clog2(DEPTH + 1);

    logic [31:0]         mem [DEPTH];
    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [CNT_BITS-1:0] count;

    assign vld     = (count != '0);
    assign rd_data = mem[rd_ptr];    // Head word is visible before the ack

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr) begin
                wr_ptr <= (wr_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (ack) begin
                rd_ptr <= (rd_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CNT_BITS'(wr) - CNT_BITS'(ack);
        end
    end

    always_ff @(posedge clk) begin
        if (wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // The network is trusted not to overfill the buffer
    a_no_overflow: assert property (@(posedge clk) disable iff (rst)
        wr |-> (count != CNT_BITS'(DEPTH)));

    a_no_underflow: assert property (@(posedge clk) disable iff (rst)
        ack |-> vld);

endmodule

// ==== hw/packet_rx.sv ====
`timescale 1ns/1ps

module packet_rx import leaf_pkg::*; #(
    parameter logic [LEAF_BITS-1:0] OWN_LEAF = 5'd3
) (
    input  logic         clk,
    input  logic         rst,
    input  leaf_packet_t din,
    output logic [1:0]   fifo_wr,
    output logic [31:0]  wr_data,
    output cfg_cmd_t     cfg
);

    logic      mine;
    cfg_kind_e cfg_kind;
    logic [1:0] cfg_port;

    function automatic cfg_kind_e decode_kind(input logic [1:0] bits);
        cfg_kind_e kind;
        case (bits)
            CFG_SET_DEST:   kind = CFG_SET_DEST;
            CFG_ADD_CREDIT: kind = CFG_ADD_CREDIT;
            default:        kind = CFG_NONE;    // Unknown kinds are dropped
        endcase
        return kind;
    endfunction

    assign mine = din.valid && (din.leaf == OWN_LEAF);

    always_ff @(posedge clk) begin
        if (rst) begin
            fifo_wr  <= '0;
            cfg_kind <= CFG_NONE;
        end else begin
            fifo_wr  <= '0;
            cfg_kind <= CFG_NONE;
            if (mine) begin
                case (din.port)
                    4'd0: cfg_kind <= decode_kind(din.addr[ADDR_BITS-1 -: 2]);
                    4'd1: fifo_wr  <= 2'b01;
                    4'd2: fifo_wr  <= 2'b10;
                    default: ;    // Ports 3 and up do not exist on this leaf
                endcase
            end
        end
    end

    // Payload is shared by data writes and control values
    always_ff @(posedge clk) begin
        wr_data  <= din.payload;
        cfg_port <= din.addr[1:0];
    end

    always_comb begin
        cfg.kind     = cfg_kind;
        cfg.out_port = cfg_port;
        cfg.value    = wr_data;
    end

    a_wr_onehot: assert property (@(posedge clk) disable iff (rst)
        $onehot0(fifo_wr));

endmodule

// ==== hw/pair_kernel.sv ====
`timescale 1ns/1ps

module pair_kernel import leaf_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 ap_start,
    input  logic [1:0][31:0]     in_data,
    input  logic [1:0]           in_vld,
    output logic [1:0]           in_ack,
    output kernel_result_t [2:0] res,
    input  logic [2:0]           res_ack
);

    logic              started;
    logic              fire;
    logic [2:0]        res_vld;
    logic [2:0][31:0]  res_data;
    logic [31:0]       total;
    logic [31:0]       sum;
    logic [31:0]       diff;

    assign sum  = in_data[0] + in_data[1];
    assign diff = in_data[0] - in_data[1];

    // Take a new pair only when all three slots have drained
    assign fire   = started && (&in_vld) && (res_vld == 3'b000);
    assign in_ack = {2{fire}};

    always_ff @(posedge clk) begin
        if (rst) begin
            started <= 1'b0;
            res_vld <= '0;
            total   <= '0;
        end else begin
            if (ap_start) begin
                started <= 1'b1;
            end
            res_vld <= res_vld & ~res_ack;
            if (fire) begin
                res_vld <= 3'b111;
                total   <= total + sum;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            res_data[0] <= sum;
            res_data[1] <= diff;
            res_data[2] <= total + sum;    // Includes the current pair
        end
    end

    always_comb begin
        for (int i = 0; i < 3; i++) begin
            res[i].vld  = res_vld[i];
            res[i].data = res_data[i];
        end
    end

    for (genvar i = 0; i < 3; i++) begin : g_hold
        // Result is held unchanged until the sender takes it
        a_res_hold: assert property (@(posedge clk) disable iff (rst)
            (res_vld[i] && !res_ack[i]) |=> (res_vld[i] && $stable(res_data[i])));
    end

endmodule

// ==== hw/packet_tx.sv ====
`timescale 1ns/1ps

module packet_tx import leaf_pkg::*; #(
    parameter int CREDIT_BITS = 8
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 resend,
    input  cfg_cmd_t             cfg,
    input  kernel_result_t [2:0] res,
    output logic [2:0]           res_ack,
    output leaf_packet_t         dout
);

    localparam int DEST_BITS = LEAF_BITS + PORT_BITS;
    localparam logic [32:0] CREDIT_MAX = 33'((64'd1 << CREDIT_BITS) - 1);

    logic [CREDIT_BITS-1:0] credit      [3];
    logic [32:0]            credit_next [3];
    logic [DEST_BITS-1:0]   dest        [3];
    logic [2:0]             eligible;
    logic [1:0]             last;
    logic [1:0]             cand;
    logic [1:0]             grant_idx;
    logic                   found;
    tx_state_e              state;
    leaf_packet_t           pkt_next;
    logic [PACKET_BITS-1:0] pkt_q;

    function automatic logic [1:0] next_port(input logic [1:0] p);
        return (p == 2'd2) ? 2'd0 : p + 2'd1;
    endfunction

    always_comb begin
        for (int i = 0; i < 3; i++) begin
            eligible[i] = res[i].vld && (credit[i] != '0) && !resend;
        end
    end

    // Search starts just after the last granted port
    always_comb begin
        res_ack   = '0;
        grant_idx = last;
        found     = 1'b0;
        cand      = last;
        for (int k = 0; k < 3; k++) begin
            cand = next_port(cand);
            if (!found && eligible[cand]) begin
                found     = 1'b1;
                grant_idx = cand;
            end
        end
        if (found) begin
            res_ack[grant_idx] = 1'b1;
        end
    end

    always_comb begin
        pkt_next.valid   = 1'b1;
        pkt_next.leaf    = dest[grant_idx][DEST_BITS-1 -: LEAF_BITS];
        pkt_next.port    = dest[grant_idx][PORT_BITS-1:0];
        pkt_next.addr    = ADDR_BITS'(grant_idx) + 1'b1;
        pkt_next.payload = res[grant_idx].data;
    end

    for (genvar i = 0; i < 3; i++) begin : g_port
        always_comb begin
            credit_next[i] = 33'(credit[i]) - 33'(res_ack[i]);
            if (cfg.kind == CFG_ADD_CREDIT && cfg.out_port == 2'(i)) begin
                credit_next[i] = credit_next[i] + 33'(cfg.value);
            end
        end

        always_ff @(posedge clk) begin
            if (rst) begin
                credit[i] <= '0;
                dest[i]   <= '0;
            end else begin
                credit[i] <= (credit_next[i] > CREDIT_MAX) ? CREDIT_MAX[CREDIT_BITS-1:0]
                                                           : credit_next[i][CREDIT_BITS-1:0];
                if (cfg.kind == CFG_SET_DEST && cfg.out_port == 2'(i)) begin
                    dest[i] <= cfg.value[DEST_BITS-1:0];
                end
            end
        end

        a_grant_credit: assert property (@(posedge clk) disable iff (rst)
            res_ack[i] |-> (credit[i] != '0 && res[i].vld));
    end

    // A packet caught by resend stays in TX_SEND until it can go out
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= TX_IDLE;
            last  <= 2'd2;
        end else if (found) begin
            state <= TX_SEND;
            last  <= grant_idx;
        end else if (!resend) begin
            state <= TX_IDLE;
        end
    end

    always_ff @(posedge clk) begin
        if (found) begin
            pkt_q <= pkt_next;
        end
    end

    assign dout = (state == TX_SEND && !resend) ? leaf_packet_t'(pkt_q) : '0;

    a_ack_onehot: assert property (@(posedge clk) disable iff (rst)
        $onehot0(res_ack));

endmodule

// ==== hw/leaf_top.sv ====
`timescale 1ns/1ps

module leaf_top import leaf_pkg::*; #(
    parameter int                   FIFO_DEPTH  = 8,
    parameter int                   CREDIT_BITS = 8,
    parameter logic [LEAF_BITS-1:0] OWN_LEAF    = 5'd3
) (
    input  logic         clk,
    input  logic         rst,
    input  logic         ap_start,
    input  logic         resend,
    input  leaf_packet_t din,
    output leaf_packet_t dout
);

    logic [1:0]           fifo_wr;
    logic [31:0]          wr_data;
    cfg_cmd_t             cfg;
    logic [1:0][31:0]     fifo_data;
    logic [1:0]           fifo_vld;
    logic [1:0]           fifo_ack;
    kernel_result_t [2:0] res;
    logic [2:0]           res_ack;

    packet_rx #(
        .OWN_LEAF(OWN_LEAF)
    ) u_rx (
        .clk    (clk),
        .rst    (rst),
        .din    (din),
        .fifo_wr(fifo_wr),
        .wr_data(wr_data),
        .cfg    (cfg)
    );

    port_fifo #(
        .DEPTH(FIFO_DEPTH)
    ) u_fifo0 (
        .clk    (clk),
        .rst    (rst),
        .wr     (fifo_wr[0]),
        .wr_data(wr_data),
        .rd_data(fifo_data[0]),
        .vld    (fifo_vld[0]),
        .ack    (fifo_ack[0])
    );

    port_fifo #(
        .DEPTH(FIFO_DEPTH)
    ) u_fifo1 (
        .clk    (clk),
        .rst    (rst),
        .wr     (fifo_wr[1]),
        .wr_data(wr_data),
        .rd_data(fifo_data[1]),
        .vld    (fifo_vld[1]),
        .ack    (fifo_ack[1])
    );

    pair_kernel u_kernel (
        .clk     (clk),
        .rst     (rst),
        .ap_start(ap_start),
        .in_data (fifo_data),
        .in_vld  (fifo_vld),
        .in_ack  (fifo_ack),
        .res     (res),
        .res_ack (res_ack)
    );

    packet_tx #(
        .CREDIT_BITS(CREDIT_BITS)
    ) u_tx (
        .clk    (clk),
        .rst    (rst),
        .resend (resend),
        .cfg    (cfg),
        .res    (res),
        .res_ack(res_ack),
        .dout   (dout)
    );

endmodule

// ==== tb/leaf_checker.sv ====
`timescale 1ns/1ps

module leaf_checker import leaf_pkg::*; #(
    parameter logic [LEAF_BITS-1:0] OWN_LEAF   = 5'd3,
    parameter int                   CREDIT_MAX = 255
) (
    input  logic         clk,
    input  logic         rst,
    input  logic         ap_start,
    input  logic         resend,
    input  leaf_packet_t din,
    input  leaf_packet_t dout,
    input  logic [95:0]  test_name,
    output int           errors,
    output int           pending,
    output int           sent
);

    logic [31:0] word_a [$];
    logic [31:0] word_b [$];
    logic [31:0] expect_q [3][$];    // Payloads per output port in send order
    logic [8:0]  dest [3];
    int          credit [3];
    logic [31:0] total;
    logic        started;

    // Falling edge keeps sampling away from the DUT edge and the input drive
    always @(negedge clk) begin
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] want;
        int          p;
        if (rst) begin
            started = 1'b0;
            total   = '0;
            word_a.delete();
            word_b.delete();
            for (int i = 0; i < 3; i++) begin
                expect_q[i].delete();
                dest[i]   = '0;
                credit[i] = 0;
            end
            if (dout != '0) begin
                $display("Failure: dout is not zero during reset");
                errors++;
            end
        end else begin
            started = started | ap_start;
            if (resend && dout != '0) begin
                $display("Failure in %0s: dout is not zero while resend is high", test_name);
                errors++;
            end
            if (din.valid && din.leaf == OWN_LEAF) begin
                p = int'(din.addr[1:0]);
                if (din.port == 4'd0 && p < 3 && din.addr[6:5] == CFG_SET_DEST) begin
                    dest[p] = din.payload[8:0];
                end else if (din.port == 4'd0 && p < 3 && din.addr[6:5] == CFG_ADD_CREDIT) begin
                    credit[p] = credit[p] + int'(din.payload);
                    if (credit[p] > CREDIT_MAX) begin
                        credit[p] = CREDIT_MAX;    // Counter saturates
                    end
                end else if (din.port == 4'd1) begin
                    word_a.push_back(din.payload);
                end else if (din.port == 4'd2) begin
                    word_b.push_back(din.payload);
                end
                if (word_a.size() != 0 && word_b.size() != 0) begin
                    a = word_a.pop_front();
                    b = word_b.pop_front();
                    total = total + a + b;
                    expect_q[0].push_back(a + b);
                    expect_q[1].push_back(a - b);
                    expect_q[2].push_back(total);
                end
            end
            if (dout.valid) begin
                sent++;
                if (!started) begin
                    $display("Failure in %0s: a packet left before ap_start", test_name);
                    errors++;
                end
                if (dout.addr < 7'd1 || dout.addr > 7'd3) begin
                    $display("Failure in %0s: packet with bad addr %0d", test_name, dout.addr);
                    errors++;
                end else begin
                    p = int'(dout.addr) - 1;
                    if (credit[p] == 0) begin
                        $display("Failure in %0s: port %0d sent without credit", test_name, p + 1);
                        errors++;
                    end else begin
                        credit[p]--;
                    end
                    if (expect_q[p].size() == 0) begin
                        $display("Failure in %0s: unexpected packet on port %0d", test_name, p + 1);
                        errors++;
                    end else begin
                        want = expect_q[p].pop_front();
                        if ({dout.leaf, dout.port, dout.payload} != {dest[p], want}) begin
                            $display("** Error %0s: port %0d expected %h, got %h", test_name,
                                     p + 1, {dest[p], want}, {dout.leaf, dout.port, dout.payload});
                            errors++;
                        end
                    end
                end
            end else if (!resend && dout != '0) begin
                $display("Failure in %0s: dout is not zero while no packet is sent", test_name);
                errors++;
            end
        end
        pending = word_a.size() + word_b.size() + expect_q[0].size() + expect_q[1].size()
                + expect_q[2].size();
    end

endmodule

// ==== tb/tb_leaf.sv ====
`timescale 1ns/1ps

module tb_leaf import leaf_pkg::*; ();

    localparam logic [LEAF_BITS-1:0] OWN_LEAF = 5'd3;
    localparam int NUM_TESTS = 6;

    typedef struct packed {
        logic [95:0]     name;
        logic [7:0]      pairs;
        logic [2:0][7:0] credit;         // Credits per output port, port 0 lowest
        logic            resend;
        logic            start_after;    // ap_start only once the pairs are loaded
        logic            noise;
        logic            rand_credit;
    } test_entry_t;

    localparam test_entry_t TESTS [NUM_TESTS] = '{
        '{"start_hold", 8'd5, {8'd5, 8'd5, 8'd5}, 1'b0, 1'b1, 1'b0, 1'b0},
        '{"basic", 8'd4, {8'd4, 8'd4, 8'd4}, 1'b0, 1'b0, 1'b0, 1'b0},
        '{"no_credit", 8'd5, {8'd3, 8'd0, 8'd3}, 1'b0, 1'b0, 1'b0, 1'b0},
        '{"resend", 8'd6, {8'd6, 8'd6, 8'd6}, 1'b1, 1'b0, 1'b0, 1'b0},
        '{"foreign", 8'd4, {8'd4, 8'd4, 8'd4}, 1'b0, 1'b0, 1'b1, 1'b0},
        '{"random", 8'd40, {8'd0, 8'd0, 8'd0}, 1'b0, 1'b0, 1'b0, 1'b1}
    };

    logic         clk;
    logic         rst;
    logic         ap_start;
    logic         resend;
    leaf_packet_t din;
    leaf_packet_t dout;
    logic [95:0]  test_name;
    logic [31:0]  seed;
    logic         timed_out;
    int           errors;
    int           pending;
    int           sent;
    int           hold_errors;
    int           err_start;
    int           hold_start;
    int           tests_passed;
    int           tests_failed;

    leaf_top #(
        .FIFO_DEPTH (8),
        .CREDIT_BITS(8),
        .OWN_LEAF   (OWN_LEAF)
    ) u_dut (
        .clk     (clk),
        .rst     (rst),
        .ap_start(ap_start),
        .resend  (resend),
        .din     (din),
        .dout    (dout)
    );

    leaf_checker #(
        .OWN_LEAF(OWN_LEAF)
    ) u_chk (
        .clk      (clk),
        .rst      (rst),
        .ap_start (ap_start),
        .resend   (resend),
        .din      (din),
        .dout     (dout),
        .test_name(test_name),
        .errors   (errors),
        .pending  (pending),
        .sent     (sent)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] next_random();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    // Each packet is held for one cycle, then the bus idles for one
    task automatic send_packet(input logic [LEAF_BITS-1:0] dst_leaf,
                               input logic [PORT_BITS-1:0] dst_port,
                               input logic [ADDR_BITS-1:0] addr, input logic [31:0] payload);
        @(posedge clk);
        #1;
        din = '{valid: 1'b1, leaf: dst_leaf, port: dst_port, addr: addr, payload: payload};
        @(posedge clk);
        #1;
        din = '0;
    endtask

    task automatic send_config(input cfg_kind_e kind, input int out_port, input logic [31:0] value);
        send_packet(OWN_LEAF, 4'd0, {kind, 3'b000, 2'(out_port)}, value);
    endtask

    task automatic pulse_signal(input bit is_resend, input int cycles);
        @(posedge clk);
        #1;
        if (is_resend) resend = 1'b1;
        else ap_start = 1'b1;
        repeat (cycles) @(posedge clk);
        #1;
        resend   = 1'b0;
        ap_start = 1'b0;
    endtask

    task automatic wait_pending(input int limit, input int max_cycles);
        int cycles;
        cycles = 0;
        while (pending > limit && !timed_out) begin
            @(posedge clk);
            cycles++;
            if (cycles >= max_cycles) begin
                $display("Timeout in %0s: %0d packets still missing after %0d cycles",
                         test_name, pending, max_cycles);
                timed_out = 1'b1;
            end
        end
    endtask

    task automatic run_test(input test_entry_t t, input int idx);
        int with_credit;
        with_credit = 0;
        test_name = t.name;
        for (int p = 0; p < 3; p++) begin
            send_config(CFG_SET_DEST, p, 32'({5'(idx * 4 + p + 8), 4'(idx + p)}));
            if (t.noise) begin
                send_packet(OWN_LEAF + 5'd1, 4'd0, {CFG_SET_DEST, 3'b000, 2'(p)}, 32'h1ff);
            end
            if (!t.rand_credit && t.credit[p] != 8'd0) begin
                send_config(CFG_ADD_CREDIT, p, 32'(t.credit[p]));
                with_credit++;
            end
        end
        if (!t.start_after) pulse_signal(1'b0, 1);
        for (int n = 0; n < int'(t.pairs); n++) begin
            if (t.rand_credit) begin
                for (int p = 0; p < 3; p++) begin
                    send_config(CFG_ADD_CREDIT, p, 32'd1 + next_random() % 32'd3);
                end
            end
            wait_pending(18, 500);    // Keeps the input FIFOs from overfilling
            if (timed_out) return;
            send_packet(OWN_LEAF, 4'd1, 7'd0, next_random());
            send_packet(OWN_LEAF, 4'd2, 7'd0, next_random());
            if (t.noise) begin
                send_packet(OWN_LEAF + 5'd2, 4'd1, 7'd0, next_random());
                send_packet(OWN_LEAF, 4'd3, 7'd0, next_random());
                send_packet(OWN_LEAF, 4'd12, {CFG_ADD_CREDIT, 5'd0}, 32'd50);
            end
            if (t.resend && n == int'(t.pairs) / 2) pulse_signal(1'b1, 6);
        end
        if (t.start_after) begin
            repeat (20) @(posedge clk);
            pulse_signal(1'b0, 1);
        end
        if (!t.rand_credit && with_credit < 3) begin
            repeat (40) @(posedge clk);    // Kernel stalls on the port without credit
            if (sent - hold_start != with_credit) begin
                $display("** Error %0s: expected %0d packets before the stall, got %0d",
                         test_name, with_credit, sent - hold_start);
                hold_errors++;
            end
            for (int p = 0; p < 3; p++) begin
                send_config(CFG_ADD_CREDIT, p, 32'(t.pairs));
            end
        end
        wait_pending(0, 3000);
    endtask

    initial begin
        clk       = 1'b0;
        rst       = 1'b1;
        ap_start  = 1'b0;
        resend    = 1'b0;
        din       = '0;
        seed      = 32'h7d462f28;
        timed_out = 1'b0;
        test_name = "reset";
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        for (int i = 0; i < NUM_TESTS; i++) begin
            if (!timed_out) begin
                err_start  = errors + hold_errors;
                hold_start = sent;
                run_test(TESTS[i], i);
                if (!timed_out && errors + hold_errors == err_start) begin
                    $display("Test %0s finished: ok", TESTS[i].name);
                    tests_passed++;
                end else begin
                    $display("Test %0s finished: FAILED", TESTS[i].name);
                    tests_failed++;
                end
            end
        end
        $display("Tests passed: %0d, tests failed: %0d, errors: %0d", tests_passed,
                 tests_failed, errors + hold_errors);
        if (tests_failed == 0 && errors + hold_errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// ==== project.f ====
hw/leaf_pkg.sv
hw/port_fifo.sv
hw/packet_rx.sv
hw/pair_kernel.sv
hw/packet_tx.sv
hw/leaf_top.sv
tb/leaf_checker.sv
tb/tb_leaf.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --assert -j 0 --top-module tb_leaf -f project.f; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_leaf)
status=$?
echo "$out"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "sim passed"; then
    exit 0
fi
exit 1
